// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Ihdl
TOP       = tbCoreBus
FILELIST  = build.f

SRCS = $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+hdl
hdl/ahbPkg.sv
hdl/corePkg.sv
hdl/busArbiter.sv
hdl/beatCounter.sv
hdl/ahbRequestMux.sv
hdl/stallControl.sv
hdl/coreBusUnit.sv
sim/ahbMemModel.sv
sim/tbCoreBus.sv

// File: hdl/ahbPkg.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite encodings
// transfer type, burst and size fields as seen on the bus
//////////////////////////////////////////////////////////////////////

package ahbPkg;

  // HTRANS, BUSY is never issued by this master
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // HBURST
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR4  = 3'b011             // line fill
  } hburstT;

  // HSIZE, bytes = 2**HSIZE
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsizeT;

endpackage

// File: hdl/ahbRequestMux.sv
//////////////////////////////////////////////////////////////////////
// AHB request path
// holds the granted request, steps burst addresses, builds strobes
// and returns read data to the owner of the transfer
//////////////////////////////////////////////////////////////////////

`include "busCfg.svh"

module ahbRequestMux (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   capture,
  input  corePkg::busOwnerT      grant,
  input  logic                   addrAccept,
  input  logic                   dataDone,
  input  logic [`BUS_ADR_W-1:0]  ifuAdr,
  input  logic [`BUS_ADR_W-1:0]  lsuAdr,
  input  logic                   lsuWrite,
  input  ahbPkg::hsizeT          lsuSize,
  input  logic [`BUS_DATA_W-1:0] lsuWdata,
  input  logic [`BUS_DATA_W-1:0] HRDATA,
  output logic [`BUS_ADR_W-1:0]  HADDR,
  output logic                   HWRITE,
  output ahbPkg::hsizeT          HSIZE,
  output logic [`BUS_STRB_W-1:0] HWSTRB,
  output logic [`BUS_DATA_W-1:0] HWDATA,
  output logic [`BUS_DATA_W-1:0] ifuRdata,
  output logic                   ifuValid,
  output logic [`BUS_DATA_W-1:0] lsuRdata,
  output logic                   lsuReady
);

  localparam int unsigned BeatBytes = `BUS_STRB_W;

  corePkg::busOwnerT      ownerQ;
  logic [`BUS_DATA_W-1:0] wdataQ;      // store data waiting for its data phase
  logic [`BUS_STRB_W-1:0] strbNext;

  // byte lanes of the current address phase
  always_comb begin
    strbNext = '0;
    if (HWRITE) begin
      unique case (HSIZE)
        ahbPkg::BYTE: strbNext[HADDR[1:0]] = 1'b1;
        ahbPkg::HALF: strbNext[{HADDR[1], 1'b0} +: 2] = 2'b11;
        default:      strbNext = '1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ownerQ <= corePkg::OWNER_FETCH;
      HADDR  <= '0;
      HWRITE <= 1'b0;
      HSIZE  <= ahbPkg::WORD;
      HWSTRB <= '0;
    end else if (capture) begin
      ownerQ <= grant;
      if (grant == corePkg::OWNER_MEM) begin
        HADDR  <= lsuAdr;
        HWRITE <= lsuWrite;
        HSIZE  <= lsuSize;
      end else begin
        HADDR  <= ifuAdr;              // fetches are word reads
        HWRITE <= 1'b0;
        HSIZE  <= ahbPkg::WORD;
      end
    end else if (addrAccept) begin
      HADDR  <= HADDR + BeatBytes[`BUS_ADR_W-1:0];
      HWSTRB <= strbNext;              // strobes belong to the data phase
    end
  end

  // write data follows its address by one phase
  always_ff @(posedge clk) begin
    if (capture) wdataQ <= lsuWdata;
    if (addrAccept) HWDATA <= wdataQ;
  end

  //////////////////////////////////////////////////////////////////////
  // read return
  //////////////////////////////////////////////////////////////////////

  assign ifuValid = dataDone && (ownerQ == corePkg::OWNER_FETCH);
  assign lsuReady = dataDone && (ownerQ == corePkg::OWNER_MEM);
  assign ifuRdata = HRDATA;
  assign lsuRdata = HRDATA;

endmodule

// File: hdl/beatCounter.sv
//////////////////////////////////////////////////////////////////////
// fetch beat counter
// counts finished data beats of a line fill, flags the last one
//////////////////////////////////////////////////////////////////////

`include "busCfg.svh"

module beatCounter (
  input  logic clk,
  input  logic rstN,
  input  logic dataDone,
  input  logic capture,
  output logic lastBeat
);

  localparam int unsigned LastIdx = `FETCH_BEATS - 1;

  logic [`BEAT_CNT_W-1:0] beatCnt;

  assign lastBeat = (beatCnt == LastIdx[`BEAT_CNT_W-1:0]);

  // holds at the last index until the next grant
  always_ff @(posedge clk) begin
    if (!rstN) begin
      beatCnt <= '0;
    end else if (capture) begin
      beatCnt <= '0;                   // new transfer
    end else if (dataDone && !lastBeat) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

endmodule

// File: hdl/busArbiter.sv
//////////////////////////////////////////////////////////////////////
// external bus arbiter
// grants the shared AHB-Lite port to fetch or load/store and
// sequences the transfer types of single and burst accesses
//////////////////////////////////////////////////////////////////////

module busArbiter (
  input  logic              clk,
  input  logic              rstN,
  input  logic              ifuReq,
  input  logic              lsuReq,
  input  logic              HREADY,
  input  logic              lastBeat,
  output corePkg::busOwnerT grant,
  output logic              capture,
  output ahbPkg::htransT    HTRANS,
  output ahbPkg::hburstT    HBURST,
  output logic              addrAccept,
  output logic              dataDone
);

  corePkg::arbStateT state, nextState;
  logic              seqQ;        // first burst beat already accepted
  logic              dataPhaseQ;  // a data phase is on the bus

  // load/store wins a tie
  assign grant   = lsuReq ? corePkg::OWNER_MEM : corePkg::OWNER_FETCH;
  assign capture = (state == corePkg::ARB_IDLE) && (ifuReq || lsuReq);

  assign addrAccept = HREADY && ((HTRANS == ahbPkg::NONSEQ) || (HTRANS == ahbPkg::SEQ));
  assign dataDone   = HREADY && dataPhaseQ;

  //////////////////////////////////////////////////////////////////////
  // transfer type and next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (state)
      corePkg::ARB_MEM:   HTRANS = ahbPkg::NONSEQ;
      corePkg::ARB_FETCH: begin
        // three data beats done means the fourth address went out
        if (lastBeat) HTRANS = ahbPkg::IDLE;
        else if (seqQ) HTRANS = ahbPkg::SEQ;
        else HTRANS = ahbPkg::NONSEQ;
      end
      default:            HTRANS = ahbPkg::IDLE;
    endcase
  end

  always_comb begin
    nextState = state;
    unique case (state)
      corePkg::ARB_IDLE: begin
        if (lsuReq) nextState = corePkg::ARB_MEM;
        else if (ifuReq) nextState = corePkg::ARB_FETCH;
      end
      corePkg::ARB_MEM:   if (addrAccept) nextState = corePkg::ARB_DRAIN;
      corePkg::ARB_FETCH: if (lastBeat) nextState = dataDone ? corePkg::ARB_IDLE
                                                             : corePkg::ARB_DRAIN;
      corePkg::ARB_DRAIN: if (dataDone) nextState = corePkg::ARB_IDLE;
      default:            nextState = corePkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state      <= corePkg::ARB_IDLE;
      seqQ       <= 1'b0;
      dataPhaseQ <= 1'b0;
      HBURST     <= ahbPkg::SINGLE;
    end else begin
      state <= nextState;
      if (capture) begin
        seqQ   <= 1'b0;
        HBURST <= (grant == corePkg::OWNER_FETCH) ? ahbPkg::INCR4 : ahbPkg::SINGLE;
      end else if (addrAccept) begin
        seqQ <= 1'b1;
      end
      if (addrAccept) dataPhaseQ <= 1'b1;   // pipelined into the next cycle
      else if (HREADY) dataPhaseQ <= 1'b0;
    end
  end

endmodule

// File: hdl/busCfg.svh
//////////////////////////////////////////////////////////////////////
// bus unit configuration
// widths and burst length shared by the external bus unit blocks
//////////////////////////////////////////////////////////////////////

`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// address and data path
`define BUS_ADR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4            // one strobe per data byte

//////////////////////////////////////////////////////////////////////
// instruction line fill
//////////////////////////////////////////////////////////////////////

// beats per line fill burst
`define FETCH_BEATS 4
`define BEAT_CNT_W 2            // must hold FETCH_BEATS-1

`endif

// File: hdl/coreBusUnit.sv
//////////////////////////////////////////////////////////////////////
// core external bus unit
// one AHB-Lite master port shared by fetch and load/store,
// plus the stage stalls that depend on it
//////////////////////////////////////////////////////////////////////

`include "busCfg.svh"

module coreBusUnit (
  input  logic                   clk,
  input  logic                   rstN,
  // fetch side
  input  logic                   ifuReq,
  input  logic [`BUS_ADR_W-1:0]  ifuAdr,
  output logic [`BUS_DATA_W-1:0] ifuRdata,
  output logic                   ifuValid,
  // load/store side
  input  logic                   lsuReq,
  input  logic                   lsuWrite,
  input  logic [`BUS_ADR_W-1:0]  lsuAdr,
  input  ahbPkg::hsizeT          lsuSize,
  input  logic [`BUS_DATA_W-1:0] lsuWdata,
  output logic [`BUS_DATA_W-1:0] lsuRdata,
  output logic                   lsuReady,
  // AHB-Lite master
  input  logic [`BUS_DATA_W-1:0] HRDATA,
  input  logic                   HREADY,
  output logic [`BUS_ADR_W-1:0]  HADDR,
  output logic [`BUS_DATA_W-1:0] HWDATA,
  output logic [`BUS_STRB_W-1:0] HWSTRB,
  output logic                   HWRITE,
  output ahbPkg::hsizeT          HSIZE,
  output ahbPkg::hburstT         HBURST,
  output ahbPkg::htransT         HTRANS,
  // stalls
  input  logic                   ExternalStall,
  output logic                   StallF,
  output logic                   StallD,
  output logic                   StallE,
  output logic                   StallM,
  output logic                   StallW
);

  corePkg::busOwnerT grant;
  logic              capture;
  logic              addrAccept;
  logic              dataDone;
  logic              lastBeat;

  // grant and transfer sequencing
  busArbiter arb (.clk, .rstN, .ifuReq, .lsuReq, .HREADY, .lastBeat,
    .grant, .capture, .HTRANS, .HBURST, .addrAccept, .dataDone);

  beatCounter beats (.clk, .rstN, .dataDone, .capture, .lastBeat);

  // address, control, write data and read return
  ahbRequestMux reqMux (.clk, .rstN, .capture, .grant, .addrAccept, .dataDone,
    .ifuAdr, .lsuAdr, .lsuWrite, .lsuSize, .lsuWdata, .HRDATA,
    .HADDR, .HWRITE, .HSIZE, .HWSTRB, .HWDATA,
    .ifuRdata, .ifuValid, .lsuRdata, .lsuReady);

  // global stalls
  stallControl hzu (.ifuReq, .ifuValid, .lsuReq, .lsuReady, .ExternalStall,
    .StallF, .StallD, .StallE, .StallM, .StallW);

endmodule

// File: hdl/corePkg.sv
//////////////////////////////////////////////////////////////////////
// core side types
// bus ownership and the external bus arbiter states
//////////////////////////////////////////////////////////////////////

package corePkg;

  // which requester owns the current transfer
  typedef enum logic {
    OWNER_FETCH = 1'b0,         // instruction line fill
    OWNER_MEM   = 1'b1          // load or store
  } busOwnerT;

  //////////////////////////////////////////////////////////////////////
  // arbiter
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ARB_IDLE  = 2'b00,          // no transfer, waiting for a request
    ARB_FETCH = 2'b01,          // burst address phases
    ARB_MEM   = 2'b10,          // single address phase
    ARB_DRAIN = 2'b11           // last data phase only
  } arbStateT;

endpackage

// File: hdl/stallControl.sv
//////////////////////////////////////////////////////////////////////
// stage stall control
// turns outstanding bus requests and external stall into stalls
//////////////////////////////////////////////////////////////////////

module stallControl (
  input  logic ifuReq,
  input  logic ifuValid,
  input  logic lsuReq,
  input  logic lsuReady,
  input  logic ExternalStall,
  output logic StallF,
  output logic StallD,
  output logic StallE,
  output logic StallM,
  output logic StallW
);

  logic memPending;
  logic fetchPending;

  // a completion pulse releases the stall in its own cycle
  assign memPending   = lsuReq && !lsuReady;
  assign fetchPending = ifuReq && !ifuValid;

  // later stages dominate earlier ones
  assign StallW = ExternalStall;
  assign StallM = StallW || memPending;
  assign StallE = StallM;
  assign StallD = StallE;
  assign StallF = StallD || fetchPending;

endmodule

// File: sim/ahbMemModel.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite slave memory
// 64 words with random wait states, for the testbench only
//////////////////////////////////////////////////////////////////////

`include "busCfg.svh"

module ahbMemModel (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`BUS_ADR_W-1:0]  HADDR,
  input  ahbPkg::htransT         HTRANS,
  input  logic                   HWRITE,
  input  ahbPkg::hsizeT          HSIZE,
  input  logic [`BUS_DATA_W-1:0] HWDATA,
  output logic [`BUS_DATA_W-1:0] HRDATA,
  output logic                   HREADY
);

  logic [`BUS_DATA_W-1:0] mem [64];
  logic [`BUS_ADR_W-1:0]  dAddr;      // data phase address
  logic                   dWrite;
  ahbPkg::hsizeT          dSize;
  logic                   pend;
  int                     waitCnt;

  // same pattern as the testbench shadow
  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return {adr[15:0], ~adr[31:16]} ^ 32'h9e3779b9;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++) mem[i] = fillWord(32'(i) << 2);
  end

  assign HRDATA = mem[dAddr[7:2]];

  always @(posedge clk) begin
    int waits;
    if (!rstN) begin
      HREADY  <= 1'b1;
      pend    <= 1'b0;
      waitCnt <= 0;
      dAddr   <= '0;
      dWrite  <= 1'b0;
      dSize   <= ahbPkg::WORD;
    end else if (HREADY) begin
      if (pend && dWrite) begin
        unique case (dSize)
          ahbPkg::BYTE: mem[dAddr[7:2]][8*dAddr[1:0] +: 8] <= HWDATA[8*dAddr[1:0] +: 8];
          ahbPkg::HALF: mem[dAddr[7:2]][16*dAddr[1] +: 16] <= HWDATA[16*dAddr[1] +: 16];
          default:      mem[dAddr[7:2]] <= HWDATA;
        endcase
      end
      if (HTRANS == ahbPkg::NONSEQ || HTRANS == ahbPkg::SEQ) begin
        waits = int'($urandom % 3);   // 0 to 2 wait states
        dAddr   <= HADDR;
        dWrite  <= HWRITE;
        dSize   <= HSIZE;
        pend    <= 1'b1;
        waitCnt <= waits;
        HREADY  <= (waits == 0);
      end else begin
        pend <= 1'b0;
      end
    end else begin
      if (waitCnt <= 1) HREADY <= 1'b1;
      waitCnt <= waitCnt - 1;
    end
  end

endmodule

// File: sim/tbCoreBus.sv
//////////////////////////////////////////////////////////////////////
// core bus unit testbench
// stores, loads, line fills and a tie, checked by assertions
//////////////////////////////////////////////////////////////////////

`include "busCfg.svh"

module tbCoreBus;

  logic clk;
  logic rstN, ifuReq, lsuReq, lsuWrite, loadCheck, tieActive;
  logic ExternalStall = 1'b0;
  logic [`BUS_ADR_W-1:0] ifuAdr, lsuAdr;
  logic [`BUS_DATA_W-1:0] lsuWdata, expLoad, ifuRdata, lsuRdata, HRDATA, HWDATA;
  ahbPkg::hsizeT lsuSize, HSIZE;
  logic ifuValid, lsuReady, HREADY, HWRITE;
  logic [`BUS_ADR_W-1:0] HADDR;
  logic [`BUS_STRB_W-1:0] HWSTRB;
  ahbPkg::hburstT HBURST;
  ahbPkg::htransT HTRANS;
  logic StallF, StallD, StallE, StallM, StallW;
  logic [31:0] shadow [64];           // expected memory contents

  coreBusUnit DUT (.*);
  ahbMemModel mem (.clk, .rstN, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HWDATA, .HRDATA, .HREADY);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return {adr[15:0], ~adr[31:16]} ^ 32'h9e3779b9;
  endfunction

  // byte lanes from size and offset
  function automatic logic [3:0] strobeFor(input ahbPkg::hsizeT size, input logic [1:0] off);
    case (size)
      ahbPkg::BYTE: return 4'b0001 << off;
      ahbPkg::HALF: return off[1] ? 4'b1100 : 4'b0011;
      default:      return 4'b1111;
    endcase
  endfunction

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic valueError(input string name, input logic [31:0] got, input logic [31:0] exp);
    reportFail($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // tracking and checks
  //////////////////////////////////////////////////////////////////////

  logic accept, reqSeen, holdPrev, dataPhase, dataWrite, tieSeen;
  logic [2:0] addrBeat, rdBeat;
  logic [3:0] expStrb;
  logic [4:0] expStalls;
  logic [31:0] prevHaddr, prevHwdata;
  ahbPkg::htransT prevHtrans;
  ahbPkg::hsizeT prevHsize;
  logic prevHwrite, memPend;

  assign accept = HREADY && (HTRANS == ahbPkg::NONSEQ || HTRANS == ahbPkg::SEQ);
  assign memPend = ExternalStall || (lsuReq && !lsuReady);
  assign expStalls = {memPend || (ifuReq && !ifuValid), memPend, memPend, memPend, ExternalStall};

  always @(posedge clk) begin
    ExternalStall <= 1'($urandom % 2);
    if (!rstN) begin
      reqSeen   <= 1'b0;
      holdPrev  <= 1'b0;
      dataPhase <= 1'b0;
    end else begin
      if (ifuReq || lsuReq) reqSeen <= 1'b1;
      holdPrev   <= !HREADY && (HTRANS != ahbPkg::IDLE || dataPhase);  // stalled phase
      prevHaddr  <= HADDR;
      prevHtrans <= HTRANS;
      prevHwrite <= HWRITE;
      prevHsize  <= HSIZE;
      prevHwdata <= HWDATA;
      if (accept) begin
        dataPhase <= 1'b1;
        dataWrite <= HWRITE;
        expStrb   <= strobeFor(HSIZE, HADDR[1:0]);
      end else if (HREADY) dataPhase <= 1'b0;
    end
    if (!ifuReq) begin                // beat counts restart per fetch
      addrBeat <= '0;
      rdBeat   <= '0;
    end else begin
      if (accept && HBURST == ahbPkg::INCR4) addrBeat <= addrBeat + 3'd1;
      if (ifuValid) rdBeat <= rdBeat + 3'd1;
    end
    if (!tieActive) tieSeen <= 1'b0;
    else if (accept && HTRANS == ahbPkg::NONSEQ) tieSeen <= 1'b1;
  end

  assert property (@(posedge clk) disable iff (!rstN)
    {StallF, StallD, StallE, StallM, StallW} == expStalls)
    else valueError("Stall", 32'({StallF, StallD, StallE, StallM, StallW}), 32'(expStalls));
  assert property (@(posedge clk) disable iff (!rstN)
    !reqSeen |-> HTRANS == ahbPkg::IDLE && !ifuValid && !lsuReady)
    else reportFail("bus activity before any request was made");
  // back-pressure
  assert property (@(posedge clk) disable iff (!rstN) holdPrev |-> HADDR == prevHaddr)
    else valueError("HADDR", HADDR, prevHaddr);
  assert property (@(posedge clk) disable iff (!rstN) holdPrev |-> HTRANS == prevHtrans)
    else valueError("HTRANS", 32'(HTRANS), 32'(prevHtrans));
  assert property (@(posedge clk) disable iff (!rstN) holdPrev |-> HWRITE == prevHwrite)
    else valueError("HWRITE", 32'(HWRITE), 32'(prevHwrite));
  assert property (@(posedge clk) disable iff (!rstN) holdPrev |-> HSIZE == prevHsize)
    else valueError("HSIZE", 32'(HSIZE), 32'(prevHsize));
  assert property (@(posedge clk) disable iff (!rstN) holdPrev |-> HWDATA == prevHwdata)
    else valueError("HWDATA", HWDATA, prevHwdata);
  assert property (@(posedge clk) disable iff (!rstN) dataPhase && dataWrite |-> HWSTRB == expStrb)
    else valueError("HWSTRB", 32'(HWSTRB), 32'(expStrb));
  assert property (@(posedge clk) disable iff (!rstN) lsuReady && loadCheck |-> lsuRdata == expLoad)
    else valueError("lsuRdata", lsuRdata, expLoad);
  // line fill sequencing
  assert property (@(posedge clk) disable iff (!rstN)
    accept && ifuReq && !lsuReq |-> HBURST == ahbPkg::INCR4 && addrBeat < 3'd4)
    else reportFail("fetch address phase outside a four beat INCR4 burst");
  assert property (@(posedge clk) disable iff (!rstN) accept && HBURST == ahbPkg::INCR4 |->
    HTRANS == (addrBeat == 3'd0 ? ahbPkg::NONSEQ : ahbPkg::SEQ))
    else valueError("HTRANS", 32'(HTRANS), 32'(addrBeat == 3'd0 ? ahbPkg::NONSEQ : ahbPkg::SEQ));
  assert property (@(posedge clk) disable iff (!rstN) accept && HBURST == ahbPkg::INCR4 |->
    HADDR == ifuAdr + (32'(addrBeat) << 2))
    else valueError("HADDR", HADDR, ifuAdr + (32'(addrBeat) << 2));
  assert property (@(posedge clk) disable iff (!rstN) ifuValid |->
    ifuRdata == fillWord(ifuAdr + (32'(rdBeat) << 2)))
    else valueError("ifuRdata", ifuRdata, fillWord(ifuAdr + (32'(rdBeat) << 2)));
  assert property (@(posedge clk) disable iff (!rstN)
    tieActive && !tieSeen && accept && HTRANS == ahbPkg::NONSEQ |-> HADDR == lsuAdr)
    else valueError("HADDR", HADDR, lsuAdr);

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic waitLsu();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 40) reportFail("timeout waiting for lsuReady");
    end while (!lsuReady);
  endtask

  task automatic storeOp(input logic [31:0] adr, input ahbPkg::hsizeT size);
    logic [31:0] data;
    logic [3:0] strb;
    data = $urandom;
    strb = strobeFor(size, adr[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) shadow[adr[7:2]][8*b +: 8] = data[8*b +: 8];
    end
    @(posedge clk);
    lsuReq   <= 1'b1;
    lsuWrite <= 1'b1;
    lsuAdr   <= adr;
    lsuSize  <= size;
    lsuWdata <= data;
    waitLsu();
    lsuReq <= 1'b0;
  endtask

  task automatic loadOp(input logic [31:0] adr);
    @(posedge clk);
    lsuReq    <= 1'b1;
    lsuWrite  <= 1'b0;
    lsuAdr    <= adr;
    lsuSize   <= ahbPkg::WORD;
    expLoad   <= shadow[adr[7:2]];
    loadCheck <= 1'b1;
    waitLsu();
    lsuReq    <= 1'b0;
    loadCheck <= 1'b0;
  endtask

  // optional load raised in the same cycle as the fetch
  task automatic fetchOp(input logic [31:0] adr, input logic withLoad, input logic [31:0] ladr);
    int n;
    int got;
    logic lsuDone;
    n = 0;
    got = 0;
    lsuDone = !withLoad;
    @(posedge clk);
    ifuReq <= 1'b1;
    ifuAdr <= adr;
    if (withLoad) begin
      lsuReq    <= 1'b1;
      lsuWrite  <= 1'b0;
      lsuAdr    <= ladr;
      lsuSize   <= ahbPkg::WORD;
      expLoad   <= shadow[ladr[7:2]];
      loadCheck <= 1'b1;
      tieActive <= 1'b1;
    end
    while (got < 4 || !lsuDone) begin
      @(posedge clk);
      n++;
      if (n > 120) reportFail("timeout waiting for fetch or load to finish");
      if (ifuValid) got++;
      if (got == 4) ifuReq <= 1'b0;
      if (lsuReady) begin
        lsuDone = 1'b1;
        lsuReq    <= 1'b0;
        loadCheck <= 1'b0;
      end
    end
    tieActive <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h4bd9a1cf));
    rstN <= 1'b0;
    ifuReq <= 1'b0;
    ifuAdr <= '0;
    lsuReq <= 1'b0;
    lsuWrite <= 1'b0;
    lsuAdr <= '0;
    lsuSize <= ahbPkg::WORD;
    lsuWdata <= '0;
    loadCheck <= 1'b0;
    tieActive <= 1'b0;
    for (int i = 0; i < 64; i++) shadow[i] = fillWord(32'(i) << 2);
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    repeat (4) @(posedge clk);
    storeOp(32'h10, ahbPkg::WORD);
    loadOp(32'h10);
    for (int k = 0; k < 4; k++) begin   // every byte lane
      storeOp(32'h14 + 32'(k), ahbPkg::BYTE);
      loadOp(32'h14);
    end
    storeOp(32'h18, ahbPkg::HALF);
    loadOp(32'h18);
    storeOp(32'h1a, ahbPkg::HALF);
    loadOp(32'h18);
    fetchOp(32'h80, 1'b0, '0);
    fetchOp(32'ha0, 1'b0, '0);
    fetchOp(32'hc0, 1'b1, 32'h14);      // tie where the load goes first
    repeat (3) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule
